// File: project.f
source/sdram_pkg.sv
source/row_tracker.sv
source/cmd_timer.sv
source/cmd_scheduler.sv
source/sdram_cmd_top.sv
testbench/tb_sdram_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the SDRAM command controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_cmd -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_sdram_cmd)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

// File: source/cmd_scheduler.sv
`timescale 1ns/1ps

module cmd_scheduler
(
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            ready,
  input  logic                            refresh_due,
  input  logic                            ras_ok,
  input  logic                            page_open,
  input  logic                            hit_rand,
  input  logic                            hit_bulk,
  input  logic                            rand_req,
  input  logic                            rand_we,
  input  logic [sdram_pkg::ADDR_W-1:0]    rand_addr,
  input  logic [sdram_pkg::MASK_W-1:0]    rand_mask,
  input  logic                            bulk_req,
  input  logic                            bulk_we,
  input  logic [sdram_pkg::ADDR_W-1:0]    bulk_addr,
  input  logic [sdram_pkg::MASK_W-1:0]    bulk_mask,
  output logic                            issue,
  output logic [sdram_pkg::CMD_W-1:0]     issued_cmd,
  output logic [sdram_pkg::PAGE_W-1:0]    new_page,
  output logic                            rand_grant,
  output logic                            bulk_grant,
  output logic [sdram_pkg::CMD_W-1:0]     sd_cmd,
  output logic [sdram_pkg::BANK_W-1:0]    sd_bank,
  output logic [sdram_pkg::SD_ADDR_W-1:0] sd_addr,
  output logic [sdram_pkg::MASK_W-1:0]    sd_mask
);

  import sdram_pkg::*;

  logic              win_req;
  logic              win_we;
  logic              win_hit;
  logic [ADDR_W-1:0] win_addr;
  logic [MASK_W-1:0] win_mask;
  logic [CMD_W-1:0]  next_cmd;
  logic              col_access; // READ or WRTE chosen this cycle
  logic [ROW_W-1:0]  win_row;
  logic [BANK_W-1:0] win_bank;
  logic [COL_W-1:0]  win_col;

  // bulk port has priority over the random port
  assign win_req  = bulk_req || rand_req;
  assign win_we   = bulk_req ? bulk_we : rand_we;
  assign win_hit  = bulk_req ? hit_bulk : hit_rand;
  assign win_addr = bulk_req ? bulk_addr : rand_addr;
  assign win_mask = bulk_req ? bulk_mask : rand_mask;

  assign win_row  = win_addr[ADDR_W-1 -: ROW_W];
  assign win_bank = win_addr[COL_W +: BANK_W];
  assign win_col  = win_addr[COL_W-1:0];

  // refresh first, then open-page hit, then page change
  always_comb
  begin
    next_cmd = cmd_noop;
    if (ready)
    begin
      if (refresh_due)
      begin
        if (!page_open)
        begin
          next_cmd = cmd_arsr;
        end
        else if (ras_ok)
        begin
          next_cmd = cmd_prch; // close before refresh
        end
      end
      else if (win_req)
      begin
        if (win_hit)
        begin
          next_cmd = win_we ? cmd_wrte : cmd_read;
        end
        else if (!page_open)
        begin
          next_cmd = cmd_actv;
        end
        else if (ras_ok)
        begin
          next_cmd = cmd_prch; // wrong page open
        end
      end
    end
  end

  assign issue      = (next_cmd != cmd_noop);
  assign issued_cmd = next_cmd;
  assign new_page   = win_addr[ADDR_W-1 -: PAGE_W];
  assign col_access = (next_cmd == cmd_read) || (next_cmd == cmd_wrte);

  // command bus and grants register one cycle after the decision
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      sd_cmd     <= cmd_noop;
      sd_bank    <= '0;
      sd_addr    <= ADDR_IDLE;
      sd_mask    <= '0;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
    end
    else
    begin
      sd_cmd     <= next_cmd;
      rand_grant <= col_access && !bulk_req;
      bulk_grant <= col_access && bulk_req;
      if (next_cmd == cmd_actv)
      begin
        sd_addr <= SD_ADDR_W'(win_row); // zero-extended row
        sd_bank <= win_bank;
      end
      else if (col_access)
      begin
        sd_addr <= {win_col, 1'b0}; // even column
        sd_bank <= win_bank;
        sd_mask <= win_mask;
      end
      else
      begin
        sd_addr <= ADDR_IDLE;
      end
    end
  end

  // grants are single-cycle pulses kept apart by the command spacing
  a_grant_spacing : assert property (
    @(posedge CLK) disable iff (!RST)
    (rand_grant || bulk_grant) |=> !(rand_grant || bulk_grant)
  );

endmodule

// File: source/cmd_timer.sv
`timescale 1ns/1ps

module cmd_timer
(
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         issue,
  input  logic [sdram_pkg::CMD_W-1:0]  issued_cmd,
  input  logic                         refresh_strobe,
  output logic                         ready,
  output logic                         refresh_due,
  output logic                         ras_ok
);

  import sdram_pkg::*;

  logic [TMR_W-1:0] spacing_cnt; // cycles left before the next command
  logic [TMR_W-1:0] ras_cnt; // cycles left before PRCH is allowed
  logic             strobe_q;
  logic             strobe_ack; // strobe level already served

  // spacing countdown, loaded per issued command
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      spacing_cnt <= '0;
    end
    else if (issue)
    begin
      if (issued_cmd == cmd_arsr)
      begin
        spacing_cnt <= TMR_W'(T_REFRESH - 1);
      end
      else
      begin
        spacing_cnt <= TMR_W'(T_ACCESS - 1);
      end
    end
    else if (spacing_cnt != '0)
    begin
      spacing_cnt <= spacing_cnt - 1'b1;
    end
  end

  assign ready = (spacing_cnt == '0);

  // activate-to-precharge holdoff, restarted by every ACTV
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      ras_cnt <= '0;
    end
    else if (issue && (issued_cmd == cmd_actv))
    begin
      ras_cnt <= TMR_W'(T_RAS - 1);
    end
    else if (ras_cnt != '0)
    begin
      ras_cnt <= ras_cnt - 1'b1;
    end
  end

  assign ras_ok = (ras_cnt == '0);

  // each strobe toggle asks for one refresh; ack catches up on ARSR
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      strobe_q   <= 1'b0;
      strobe_ack <= 1'b0;
    end
    else
    begin
      strobe_q <= refresh_strobe;
      if (issue && (issued_cmd == cmd_arsr))
      begin
        strobe_ack <= strobe_q;
      end
    end
  end

  assign refresh_due = strobe_q ^ strobe_ack;

  // the scheduler must respect the spacing
  a_issue_when_ready : assert property (
    @(posedge CLK) disable iff (!RST) issue |-> ready
  );

endmodule

// File: source/row_tracker.sv
`timescale 1ns/1ps

module row_tracker
(
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          issue,
  input  logic [sdram_pkg::CMD_W-1:0]   issued_cmd,
  input  logic [sdram_pkg::PAGE_W-1:0]  new_page,
  input  logic [sdram_pkg::ADDR_W-1:0]  rand_addr,
  input  logic [sdram_pkg::ADDR_W-1:0]  bulk_addr,
  output logic                          page_open,
  output logic                          hit_rand,
  output logic                          hit_bulk
);

  import sdram_pkg::*;

  logic [PAGE_W-1:0] open_page; // {row, bank} of the active page
  logic [PAGE_W-1:0] rand_page;
  logic [PAGE_W-1:0] bulk_page;

  // page is the top PAGE_W bits of the word address
  assign rand_page = rand_addr[ADDR_W-1 -: PAGE_W];
  assign bulk_page = bulk_addr[ADDR_W-1 -: PAGE_W];

  // open flag follows ACTV and PRCH
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      page_open <= 1'b0;
    end
    else if (issue)
    begin
      if (issued_cmd == cmd_actv)
      begin
        page_open <= 1'b1;
      end
      else if (issued_cmd == cmd_prch)
      begin
        page_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (issue && (issued_cmd == cmd_actv))
    begin
      open_page <= new_page; // latched with the activate
    end
  end

  // stale page contents are masked by page_open
  assign hit_rand = page_open && (rand_page == open_page);
  assign hit_bulk = page_open && (bulk_page == open_page);

  // column access needs a row that was activated earlier
  a_access_needs_open_row : assert property (
    @(posedge CLK) disable iff (!RST)
    (issue && ((issued_cmd == cmd_read) || (issued_cmd == cmd_wrte))) |-> page_open
  );

endmodule

// File: source/sdram_cmd_top.sv
`timescale 1ns/1ps

module sdram_cmd_top
(
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            refresh_strobe,
  input  logic                            rand_req,
  input  logic                            rand_we,
  input  logic [sdram_pkg::ADDR_W-1:0]    rand_addr,
  input  logic [sdram_pkg::MASK_W-1:0]    rand_mask,
  output logic                            rand_grant,
  input  logic                            bulk_req,
  input  logic                            bulk_we,
  input  logic [sdram_pkg::ADDR_W-1:0]    bulk_addr,
  input  logic [sdram_pkg::MASK_W-1:0]    bulk_mask,
  output logic                            bulk_grant,
  output logic [sdram_pkg::CMD_W-1:0]     sd_cmd,
  output logic [sdram_pkg::BANK_W-1:0]    sd_bank,
  output logic [sdram_pkg::SD_ADDR_W-1:0] sd_addr,
  output logic [sdram_pkg::MASK_W-1:0]    sd_mask
);

  import sdram_pkg::*;

  logic              issue;
  logic [CMD_W-1:0]  issued_cmd;
  logic [PAGE_W-1:0] new_page;
  logic              page_open;
  logic              hit_rand;
  logic              hit_bulk;
  logic              ready;
  logic              refresh_due;
  logic              ras_ok;

  row_tracker row_tracker0
  (
    .CLK(CLK), .RST(RST), .issue(issue), .issued_cmd(issued_cmd),
    .new_page(new_page), .rand_addr(rand_addr), .bulk_addr(bulk_addr),
    .page_open(page_open), .hit_rand(hit_rand), .hit_bulk(hit_bulk)
  );

  cmd_timer cmd_timer0
  (
    .CLK(CLK), .RST(RST), .issue(issue), .issued_cmd(issued_cmd),
    .refresh_strobe(refresh_strobe), .ready(ready),
    .refresh_due(refresh_due), .ras_ok(ras_ok)
  );

  cmd_scheduler cmd_scheduler0
  (
    .CLK(CLK), .RST(RST), .ready(ready), .refresh_due(refresh_due),
    .ras_ok(ras_ok), .page_open(page_open), .hit_rand(hit_rand),
    .hit_bulk(hit_bulk), .rand_req(rand_req), .rand_we(rand_we),
    .rand_addr(rand_addr), .rand_mask(rand_mask), .bulk_req(bulk_req),
    .bulk_we(bulk_we), .bulk_addr(bulk_addr), .bulk_mask(bulk_mask),
    .issue(issue), .issued_cmd(issued_cmd), .new_page(new_page),
    .rand_grant(rand_grant), .bulk_grant(bulk_grant), .sd_cmd(sd_cmd),
    .sd_bank(sd_bank), .sd_addr(sd_addr), .sd_mask(sd_mask)
  );

endmodule

// File: source/sdram_pkg.sv
package sdram_pkg;

  // SDRAM command bus width
  localparam int CMD_W = 3;

  // command encodings as driven on sd_cmd
  localparam logic [CMD_W-1:0] cmd_noop = 3'b111; // no operation
  localparam logic [CMD_W-1:0] cmd_actv = 3'b011; // open a row
  localparam logic [CMD_W-1:0] cmd_read = 3'b101;
  localparam logic [CMD_W-1:0] cmd_wrte = 3'b100;
  localparam logic [CMD_W-1:0] cmd_prch = 3'b010; // close the open row
  localparam logic [CMD_W-1:0] cmd_arsr = 3'b001; // auto refresh

  // requester address is {row, bank, column}
  localparam int ADDR_W = 26;
  localparam int ROW_W = 12; // bits 25..14
  localparam int BANK_W = 2; // bits 13..12
  localparam int COL_W = 12; // bits 11..0
  localparam int PAGE_W = ROW_W + BANK_W; // row plus bank, 14
  localparam int MASK_W = 4;

  localparam int SD_ADDR_W = 13;

  // address bus value when no command carries an address
  localparam logic [SD_ADDR_W-1:0] ADDR_IDLE = 13'h0400;

  // command spacing, in clock cycles
  localparam int T_ACCESS = 4; // after ACTV, READ, WRTE, PRCH
  localparam int T_REFRESH = 12; // after ARSR
  localparam int T_RAS = 6; // ACTV to PRCH minimum

  // countdown width, wide enough for T_REFRESH
  localparam int TMR_W = 4;

endpackage

// File: testbench/sdram_stimulus.txt
# id port(0 rand, 1 bulk, 2 both, 3 refresh then rand) rand_we bulk_we rand_addr bulk_addr
# rand_mask bulk_mask cmds, one hex digit per command: 3 ACTV 5 READ 4 WRTE 2 PRCH 1 ARSR
1 0 0 0 0049034 0000000 f 0 35
2 0 1 0 0049100 0000000 3 0 4
3 1 0 0 0000000 00490ff 0 c 5
4 0 0 0 0295010 0000000 a 0 235
5 1 0 1 0000000 0296200 0 6 234
6 2 0 1 0296004 0296008 1 e 45
7 2 1 0 0ffffff 0296010 7 2 5234
8 3 0 0 0fff020 0000000 b 0 2135
9 0 0 0 0fff040 0000000 4 0 5
10 2 0 1 2001555 0004002 9 5 234235
11 3 0 0 2001556 0000000 d 0 2135
12 1 0 0 0000000 2001000 0 8 5
13 1 0 1 0000000 0049034 0 9 234
14 0 0 0 0049035 0000000 0 0 5
15 2 1 0 0049fff 0049000 8 1 54
16 0 0 0 0000000 0000000 6 0 235

// File: testbench/tb_sdram_cmd.sv
`timescale 1ns/1ps

module tb_sdram_cmd;

  import sdram_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int RAND_PORT = 1; // grant code {bulk, rand}
  localparam int BULK_PORT = 2;

  logic                 CLK;
  logic                 RST;
  logic                 refresh_strobe;
  logic                 rand_req;
  logic                 rand_we;
  logic [ADDR_W-1:0]    rand_addr;
  logic [MASK_W-1:0]    rand_mask;
  logic                 rand_grant;
  logic                 bulk_req;
  logic                 bulk_we;
  logic [ADDR_W-1:0]    bulk_addr;
  logic [MASK_W-1:0]    bulk_mask;
  logic                 bulk_grant;
  logic [CMD_W-1:0]     sd_cmd;
  logic [BANK_W-1:0]    sd_bank;
  logic [SD_ADDR_W-1:0] sd_addr;
  logic [MASK_W-1:0]    sd_mask;

  // stimulus table with one entry per data line
  int          n_lines;
  int          t_id[MAX_LINES];
  int          t_port[MAX_LINES]; // 0 rand, 1 bulk, 2 both, 3 refresh then rand
  int          t_rwe[MAX_LINES];
  int          t_bwe[MAX_LINES];
  logic [31:0] t_raddr[MAX_LINES];
  logic [31:0] t_baddr[MAX_LINES];
  logic [31:0] t_rmask[MAX_LINES];
  logic [31:0] t_bmask[MAX_LINES];
  logic [31:0] t_cmds[MAX_LINES]; // one hex digit per command

  // everything seen on the command bus
  logic [CMD_W-1:0]     mon_cmd[$];
  logic [BANK_W-1:0]    mon_bank[$];
  logic [SD_ADDR_W-1:0] mon_addr[$];
  logic [MASK_W-1:0]    mon_mask[$];
  logic [1:0]           mon_grant[$];

  int cur_id = 0;
  int error_count = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int seed;
  int idle;

  sdram_cmd_top dut0
  (
    .CLK(CLK), .RST(RST), .refresh_strobe(refresh_strobe),
    .rand_req(rand_req), .rand_we(rand_we), .rand_addr(rand_addr),
    .rand_mask(rand_mask), .rand_grant(rand_grant),
    .bulk_req(bulk_req), .bulk_we(bulk_we), .bulk_addr(bulk_addr),
    .bulk_mask(bulk_mask), .bulk_grant(bulk_grant),
    .sd_cmd(sd_cmd), .sd_bank(sd_bank), .sd_addr(sd_addr), .sd_mask(sd_mask)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic check_value(input string what, input int id, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      error_count++;
      $display("ERROR test %0d %s: expected %0h, actual %0h", id, what, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // runaway guard with the limit set once the stimulus is loaded
  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit))
    begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("tests failed");
      $fatal(1);
    end
  end

  // outputs are stable at the falling edge
  always @(negedge CLK)
  begin
    if (RST)
    begin
      check_value("grant overlap", cur_id, 32'd0, 32'(rand_grant && bulk_grant));
      if ((sd_cmd != cmd_noop) || rand_grant || bulk_grant)
      begin
        mon_cmd.push_back(sd_cmd);
        mon_bank.push_back(sd_bank);
        mon_addr.push_back(sd_addr);
        mon_mask.push_back(sd_mask);
        mon_grant.push_back({bulk_grant, rand_grant});
      end
    end
  end

  task automatic load_stimulus();
    int          fd;
    int          cnt;
    string       line;
    int          id;
    int          port;
    int          rwe;
    int          bwe;
    logic [31:0] raddr;
    logic [31:0] baddr;
    logic [31:0] rmask;
    logic [31:0] bmask;
    logic [31:0] cmds;
    n_lines = 0;
    fd = $fopen("testbench/sdram_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file testbench/sdram_stimulus.txt");
      $display("tests failed");
      $fatal(1);
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        cnt = $fgets(line, fd);
        if ((cnt > 1) && (line.getc(0) != "#")) // skip blanks and column notes
        begin
          cnt = $sscanf(line, "%d %d %d %d %h %h %h %h %h", id, port, rwe, bwe,
                        raddr, baddr, rmask, bmask, cmds);
          if ((cnt != 9) || (n_lines == MAX_LINES))
          begin
            $display("stimulus line could not be read: %s", line);
            $display("tests failed");
            $fatal(1);
          end
          else
          begin
            t_id[n_lines] = id;
            t_port[n_lines] = port;
            t_rwe[n_lines] = rwe;
            t_bwe[n_lines] = bwe;
            t_raddr[n_lines] = raddr;
            t_baddr[n_lines] = baddr;
            t_rmask[n_lines] = rmask;
            t_bmask[n_lines] = bmask;
            t_cmds[n_lines] = cmds;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle();
    repeat (10)
    begin
      @(negedge CLK);
      check_value("idle command", 0, 32'(cmd_noop), 32'(sd_cmd));
      check_value("idle grants", 0, 32'd0, 32'({bulk_grant, rand_grant}));
      check_value("idle address", 0, 32'(ADDR_IDLE), 32'(sd_addr));
    end
    @(posedge CLK);
  endtask

  task automatic wait_grant(output int g);
    g = 0;
    while (g == 0)
    begin
      @(negedge CLK);
      g = int'({bulk_grant, rand_grant});
    end
  endtask

  // raise the requests of one line and hold each one until its grant
  task automatic run_line(input int n);
    int pending;
    int g;
    pending = (t_port[n] == 2) ? 2 : 1;
    if (t_port[n] == 3)
    begin
      refresh_strobe <= ~refresh_strobe; // one toggle, one refresh
      repeat (2) @(posedge CLK);
    end
    if (t_port[n] != 1)
    begin
      rand_req  <= 1'b1;
      rand_we   <= t_rwe[n][0];
      rand_addr <= t_raddr[n][ADDR_W-1:0];
      rand_mask <= t_rmask[n][MASK_W-1:0];
    end
    if ((t_port[n] == 1) || (t_port[n] == 2))
    begin
      bulk_req  <= 1'b1;
      bulk_we   <= t_bwe[n][0];
      bulk_addr <= t_baddr[n][ADDR_W-1:0];
      bulk_mask <= t_bmask[n][MASK_W-1:0];
    end
    while (pending > 0)
    begin
      wait_grant(g);
      @(posedge CLK);
      if (g[1])
      begin
        bulk_req <= 1'b0;
      end
      else
      begin
        rand_req <= 1'b0;
      end
      pending--;
    end
  endtask

  // page model taking each command's fields from the port being served
  task automatic compare_line(input int n);
    int          owner;
    int          n_exp;
    int          k;
    int          s;
    logic [3:0]  code;
    logic [25:0] a;
    logic [3:0]  m;
    n_exp = 0;
    for (s = 0; s < 8; s++)
    begin
      if (t_cmds[n][s*4 +: 4] != 4'h0)
      begin
        n_exp++;
      end
    end
    check_value("command count", t_id[n], 32'(n_exp), 32'(mon_cmd.size()));
    owner = ((t_port[n] == 1) || (t_port[n] == 2)) ? BULK_PORT : RAND_PORT; // bulk first
    k = 0;
    for (s = 7; s >= 0; s--)
    begin
      code = t_cmds[n][s*4 +: 4];
      if (code != 4'h0)
      begin
        a = (owner == BULK_PORT) ? t_baddr[n][25:0] : t_raddr[n][25:0];
        m = (owner == BULK_PORT) ? t_bmask[n][3:0] : t_rmask[n][3:0];
        check_value("command", t_id[n], 32'(code), 32'(mon_cmd[k]));
        if (code[2:0] == cmd_actv)
        begin
          check_value("actv bank", t_id[n], 32'(a[13:12]), 32'(mon_bank[k]));
          check_value("actv row", t_id[n], 32'(a[25:14]), 32'(mon_addr[k]));
          check_value("actv grant", t_id[n], 32'd0, 32'(mon_grant[k]));
        end
        else if ((code[2:0] == cmd_read) || (code[2:0] == cmd_wrte))
        begin
          check_value("access bank", t_id[n], 32'(a[13:12]), 32'(mon_bank[k]));
          check_value("access column", t_id[n], 32'({a[11:0], 1'b0}), 32'(mon_addr[k]));
          check_value("access mask", t_id[n], 32'(m), 32'(mon_mask[k]));
          check_value("grant port", t_id[n], 32'(owner), 32'(mon_grant[k]));
          owner = RAND_PORT; // rand follows bulk
        end
        else
        begin
          check_value("idle address", t_id[n], 32'(ADDR_IDLE), 32'(mon_addr[k]));
          check_value("stray grant", t_id[n], 32'd0, 32'(mon_grant[k]));
        end
        k++;
      end
    end
    mon_cmd.delete();
    mon_bank.delete();
    mon_addr.delete();
    mon_mask.delete();
    mon_grant.delete();
  endtask

  initial
  begin
    seed = $urandom(32'h8e1791bd);
    RST = 1'b0;
    refresh_strobe = 1'b0;
    rand_req = 1'b0;
    rand_we = 1'b0;
    rand_addr = '0;
    rand_mask = '0;
    bulk_req = 1'b0;
    bulk_we = 1'b0;
    bulk_addr = '0;
    bulk_mask = '0;
    load_stimulus();
    cycle_limit = 40 * n_lines + 100;
    repeat (8) @(posedge CLK);
    RST <= 1'b1;
    check_idle();
    for (int i = 0; i < n_lines; i++)
    begin
      idle = $urandom % 4;
      repeat (idle) @(posedge CLK);
      cur_id = t_id[i];
      run_line(i);
      compare_line(i);
    end
    repeat (30) @(negedge CLK); // no late refresh or access
    check_value("commands after the last test", 0, 32'd0, 32'(mon_cmd.size()));
    if (error_count == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
